//--- cache_bus_pkg.sv
`default_nettype none

package cache_bus_pkg;

    parameter int unsigned addr_w = 32;
    parameter int unsigned line_w = 256;
    parameter int unsigned word_w = 32;
    parameter int unsigned mask_w = word_w / 8;  // one bit per byte lane

    // cpu side, held until resp
    typedef struct packed {
        logic              read;
        logic              write;
        logic [addr_w-1:0] addr;
        logic [word_w-1:0] wdata;
        logic [mask_w-1:0] wmask;
    } cpu_req_t;

    typedef struct packed {
        logic              resp;
        logic [word_w-1:0] rdata;  // valid with resp
    } cpu_rsp_t;

    // memory side, whole lines only
    typedef struct packed {
        logic              read;
        logic              write;
        logic [addr_w-1:0] addr;   // line aligned
        logic [line_w-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic              resp;
        logic [line_w-1:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- cache_core_pkg.sv
`default_nettype none

package cache_core_pkg;

    parameter int unsigned offset_w       = 5;  // byte offset in a 256-bit line
    parameter int unsigned words_per_line = 8;

    // controller -> datapath
    typedef struct packed {
        logic cacheline_sel;   // way being accessed
        logic tag_source_sel;  // 0 stored tag, 1 cpu tag
        logic load;            // merge cpu word
        logic load_all;        // fill line from memory
        logic load_lru;
        logic lru_in;
    } ctrl_t;

    // datapath -> controller
    typedef struct packed {
        logic hit_0;
        logic hit_1;
        logic dirty_out;  // dirty bit of the lru way
        logic lru_out;    // way to evict next
    } status_t;

endpackage

`default_nettype wire

//--- cache_control.sv
`default_nettype none

module cache_control (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_bus_pkg::cpu_req_t cpu_req,
    input  cache_core_pkg::status_t status,
    input  logic                    mem_resp,
    output cache_core_pkg::ctrl_t   ctrl,
    output logic                    cpu_resp,
    output logic                    mem_read,
    output logic                    mem_write
);

    typedef enum logic [1:0] {
        st_idle_hit,
        st_write_back,
        st_read_in
    } state_t;

    state_t state;
    state_t next_state;
    logic   req_valid;
    logic   hit_any;

    assign req_valid = cpu_req.read | cpu_req.write;
    assign hit_any   = status.hit_0 | status.hit_1;

    always_comb begin
        ctrl      = '0;
        cpu_resp  = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;

        case (state)
            st_idle_hit: begin
                if (req_valid && hit_any) begin
                    ctrl.cacheline_sel = status.hit_1;
                    ctrl.lru_in        = status.hit_0;  // lru points at the other way
                    ctrl.load_lru      = 1'b1;
                    ctrl.load          = cpu_req.write;
                    cpu_resp           = 1'b1;
                end
            end

            st_write_back: begin
                ctrl.cacheline_sel  = status.lru_out;  // victim line and its stored tag
                ctrl.tag_source_sel = 1'b0;
                mem_write           = 1'b1;
            end

            st_read_in: begin
                ctrl.cacheline_sel  = status.lru_out;
                ctrl.tag_source_sel = 1'b1;            // fetch the cpu's line
                ctrl.load_all       = mem_resp;        // fill only when data is there
                mem_read            = 1'b1;
            end

            default: begin
                ctrl = '0;
            end
        endcase
    end

    always_comb begin
        next_state = state;

        case (state)
            st_idle_hit: begin
                if (req_valid && !hit_any) begin
                    if (status.dirty_out) begin
                        next_state = st_write_back;
                    end else begin
                        next_state = st_read_in;
                    end
                end
            end

            st_write_back: begin
                if (mem_resp) begin
                    next_state = st_read_in;
                end
            end

            st_read_in: begin
                if (mem_resp) begin
                    next_state = st_idle_hit;  // request hits on the next cycle
                end
            end

            default: begin
                next_state = st_idle_hit;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle_hit;
        end else begin
            state <= next_state;
        end
    end

    // one memory phase at a time
    a_mem_one_hot: assert property (@(posedge clk) disable iff (rst)
        !(mem_read && mem_write));

    a_resp_needs_req: assert property (@(posedge clk) disable iff (rst)
        cpu_resp |-> req_valid);

endmodule

`default_nettype wire

//--- cache_datapath.sv
`default_nettype none

module cache_datapath #(
    parameter int unsigned idx_bits = 3
) (
    input  logic                       clk,
    input  logic                       rst,
    input  cache_bus_pkg::cpu_req_t    cpu_req,
    input  cache_core_pkg::ctrl_t      ctrl,
    input  cache_bus_pkg::mem_rsp_t    mem_rsp,
    output cache_core_pkg::status_t    status,
    output logic [31:0]                cpu_rdata,
    output logic [31:0]                mem_addr,
    output logic [255:0]               mem_wdata
);

    import cache_bus_pkg::*;
    import cache_core_pkg::*;

    localparam int unsigned num_sets = 1 << idx_bits;
    localparam int unsigned tag_w    = addr_w - idx_bits - offset_w;
    localparam int unsigned wsel_w   = offset_w - 2;  // word select bits

    // per-way state, valid/dirty kept as bit vectors so reset can clear them
    logic [num_sets-1:0] valid_q [2];
    logic [num_sets-1:0] dirty_q [2];
    logic [num_sets-1:0] lru_q;
    logic [tag_w-1:0]    tag_q   [2][num_sets];
    logic [line_w-1:0]   data_q  [2][num_sets];

    logic [tag_w-1:0]    cpu_tag;
    logic [idx_bits-1:0] idx;
    logic [wsel_w-1:0]   word_sel;
    logic                way;
    logic [line_w-1:0]   sel_line;
    logic [line_w-1:0]   merged_line;
    logic [tag_w-1:0]    addr_tag;
    logic                lru_way;

    // address split: tag | index | word | byte
    assign cpu_tag  = cpu_req.addr[addr_w-1 -: tag_w];
    assign idx      = cpu_req.addr[offset_w +: idx_bits];
    assign word_sel = cpu_req.addr[2 +: wsel_w];
    assign way      = ctrl.cacheline_sel;
    assign lru_way  = lru_q[idx];

    assign status.hit_0     = valid_q[0][idx] && (tag_q[0][idx] == cpu_tag);
    assign status.hit_1     = valid_q[1][idx] && (tag_q[1][idx] == cpu_tag);
    assign status.dirty_out = dirty_q[lru_way][idx];
    assign status.lru_out   = lru_way;

    assign sel_line  = data_q[way][idx];
    assign cpu_rdata = sel_line[word_sel*word_w +: word_w];
    assign mem_wdata = sel_line;

    // victim tag on write-back, cpu tag on read-in
    assign addr_tag = ctrl.tag_source_sel ? cpu_tag : tag_q[way][idx];
    assign mem_addr = {addr_tag, idx, {offset_w{1'b0}}};

    // byte-masked write of one word into the selected line
    always_comb begin
        merged_line = sel_line;
        for (int w = 0; w < words_per_line; w++) begin
            for (int b = 0; b < mask_w; b++) begin
                if ((w == int'(word_sel)) && cpu_req.wmask[b]) begin
                    merged_line[w*word_w + b*8 +: 8] = cpu_req.wdata[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
            dirty_q[0] <= '0;
            dirty_q[1] <= '0;
            lru_q      <= '0;
        end else begin
            if (ctrl.load_all) begin
                valid_q[way][idx] <= 1'b1;
                dirty_q[way][idx] <= 1'b0;   // fresh line from memory
            end else if (ctrl.load) begin
                dirty_q[way][idx] <= 1'b1;
            end
            if (ctrl.load_lru) begin
                lru_q[idx] <= ctrl.lru_in;
            end
        end
    end

    // tags and line data
    always_ff @(posedge clk) begin
        if (ctrl.load_all) begin
            tag_q[way][idx]  <= cpu_tag;
            data_q[way][idx] <= mem_rsp.rdata;
        end else if (ctrl.load) begin
            data_q[way][idx] <= merged_line;
        end
    end

    // a cpu write never lands in the same cycle as a fill
    a_load_excl: assert property (@(posedge clk) disable iff (rst)
        !(ctrl.load && ctrl.load_all));

endmodule

`default_nettype wire

//--- cache_top.sv
`default_nettype none

module cache_top #(
    parameter int unsigned idx_bits = 3  // 2**idx_bits sets
) (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_bus_pkg::cpu_req_t cpu_req,
    output cache_bus_pkg::cpu_rsp_t cpu_rsp,
    output cache_bus_pkg::mem_req_t mem_req,
    input  cache_bus_pkg::mem_rsp_t mem_rsp
);

    import cache_bus_pkg::*;
    import cache_core_pkg::*;

    ctrl_t               ctrl;
    status_t             status;
    logic                cpu_resp;
    logic                mem_read;
    logic                mem_write;
    logic [word_w-1:0]   cpu_rdata;
    logic [addr_w-1:0]   mem_addr;
    logic [line_w-1:0]   mem_wdata;

    cache_control u_cache_control (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .status    (status),
        .mem_resp  (mem_rsp.resp),
        .ctrl      (ctrl),
        .cpu_resp  (cpu_resp),
        .mem_read  (mem_read),
        .mem_write (mem_write)
    );

    cache_datapath #(
        .idx_bits (idx_bits)
    ) u_cache_datapath (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .ctrl      (ctrl),
        .mem_rsp   (mem_rsp),
        .status    (status),
        .cpu_rdata (cpu_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    // bus structs
    assign cpu_rsp.resp  = cpu_resp;
    assign cpu_rsp.rdata = cpu_rdata;
    assign mem_req.read  = mem_read;
    assign mem_req.write = mem_write;
    assign mem_req.addr  = mem_addr;
    assign mem_req.wdata = mem_wdata;

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int unsigned period       = 100,
    parameter int unsigned reset_cycles = 3,
    parameter int unsigned drive_delay  = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // reset drops a little after the last reset edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #(drive_delay);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- tb_cache_top.sv
`default_nettype none

module tb_cache_top;

    import cache_bus_pkg::*;
    import cache_core_pkg::*;

    localparam int unsigned idx_bits = 3;
    localparam int unsigned num_sets = 1 << idx_bits;
    localparam int unsigned tag_w    = addr_w - idx_bits - offset_w;
    localparam int unsigned n_ops    = 400;
    localparam int unsigned period   = 100;
    localparam logic [tag_w-1:0] tag_tab [4] = '{24'h000000, 24'h000001, 24'h3c5a96, 24'hfffffe};

    logic     clk;
    logic     rst;
    cpu_req_t cpu_req;
    cpu_rsp_t cpu_rsp;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    integer      seed       = 32'hc2e94096;
    integer      delay_seed = 32'hc2e94096;  // separate stream for memory latency
    int          n_errors, n_hits, n_misses, n_wb, n_reads, n_writes;
    int          rd_seen, wb_seen;
    logic        exp_hit, exp_wb;
    logic [31:0] exp_wb_addr, exp_rd_addr;

    logic [31:0]      ref_mem   [logic [31:0]];  // cpu-visible words, by byte address
    logic [255:0]     mem_lines [logic [31:0]];  // lines written back by the cache
    logic [tag_w-1:0] m_tag     [2][num_sets];
    logic             m_valid   [2][num_sets];
    logic             m_dirty   [2][num_sets];
    logic             m_lru     [num_sets];      // way to evict next

    tb_clock_gen #(.period(period)) u_clock_gen (.clk(clk), .rst(rst));

    cache_top #(
        .idx_bits (idx_bits)
    ) u_cache_top (
        .clk     (clk),
        .rst     (rst),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h5ac31e07;
    endfunction

    function automatic logic [255:0] fill_line(input logic [31:0] base);
        logic [255:0] l;
        for (int w = 0; w < words_per_line; w++) begin
            l[w*32 +: 32] = fill_word(base + w * 4);
        end
        return l;
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] a);
        return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
    endfunction

    function automatic logic [255:0] model_line(input logic [31:0] base);
        logic [255:0] l;
        for (int w = 0; w < words_per_line; w++) begin
            l[w*32 +: 32] = model_word(base + w * 4);
        end
        return l;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                                input logic [3:0] mask);
        logic [31:0] r;
        r = old_w;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) r[b*8 +: 8] = new_w[b*8 +: 8];
        end
        return r;
    endfunction

    task automatic mismatch(input string name, input logic [255:0] got, input logic [255:0] exp);
        $display("CHECK FAILED t=%0t %s expected %0h got %0h", $time, name, exp, got);
        n_errors++;
    endtask

    task automatic problem(input string msg);
        $display("ERROR t=%0t %s", $time, msg);
        n_errors++;
    endtask

    // memory model, answers after 1 to 6 cycles
    initial begin
        logic [31:0] rnd_d;
        int          delay;
        logic        busy;
        mem_rsp = '0;
        busy    = 1'b0;
        delay   = 0;
        forever begin
            @(posedge clk);
            #10;
            if (mem_rsp.resp) begin
                mem_rsp.resp = 1'b0;  // taken at this edge
            end else if (!rst && (mem_req.read || mem_req.write)) begin
                if (!busy) begin
                    rnd_d = $random(delay_seed);
                    delay = 1 + (rnd_d[15:0] % 6);
                    busy  = 1'b1;
                end
                delay--;
                if (delay == 0) begin
                    busy = 1'b0;
                    mem_rsp.resp = 1'b1;
                    if (mem_req.write) begin
                        wb_seen++;
                        if (!exp_wb) problem("write-back raised although the victim is clean");
                        if (mem_req.addr !== exp_wb_addr) begin
                            mismatch("mem_req.addr (write-back)", mem_req.addr, exp_wb_addr);
                        end
                        if (mem_req.wdata !== model_line(exp_wb_addr)) begin
                            mismatch("mem_req.wdata", mem_req.wdata, model_line(exp_wb_addr));
                        end
                        mem_lines[mem_req.addr] = mem_req.wdata;
                    end else begin
                        rd_seen++;
                        if (exp_hit) problem("memory read raised on a predicted hit");
                        if (mem_req.addr !== exp_rd_addr) begin
                            mismatch("mem_req.addr (read-in)", mem_req.addr, exp_rd_addr);
                        end
                        mem_rsp.rdata = mem_lines.exists(mem_req.addr) ?
                                        mem_lines[mem_req.addr] : fill_line(mem_req.addr);
                    end
                end
            end
        end
    end

    initial begin
        logic [31:0]         rnd;
        logic [31:0]         addr;
        logic [31:0]         exp_rdata;
        logic [tag_w-1:0]    tag;
        logic [idx_bits-1:0] set_idx;
        logic                is_write, hit0, hit1, victim, way, got_resp, first_cycle;
        int                  err_before;
        cpu_req = '0;
        for (int s = 0; s < num_sets; s++) begin
            m_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                m_tag[w][s]   = '0;
                m_valid[w][s] = 1'b0;
                m_dirty[w][s] = 1'b0;
            end
        end

        wait (rst === 1'b0);
        @(negedge clk);
        if (cpu_rsp.resp !== 1'b0) mismatch("cpu_rsp.resp", cpu_rsp.resp, 1'b0);
        if (mem_req.read !== 1'b0) mismatch("mem_req.read", mem_req.read, 1'b0);
        if (mem_req.write !== 1'b0) mismatch("mem_req.write", mem_req.write, 1'b0);
        $display("test reset_state: %s", (n_errors == 0) ? "ok" : "errors");
        @(posedge clk);
        #10;

        err_before = n_errors;
        for (int i = 0; i < n_ops; i++) begin
            rnd      = $random(seed);
            is_write = rnd[0];
            tag      = tag_tab[rnd[2:1]];
            set_idx  = rnd[3 +: idx_bits];
            addr     = {tag, set_idx, rnd[16 +: 3], 2'b00};
            hit0     = m_valid[0][set_idx] && (m_tag[0][set_idx] == tag);
            hit1     = m_valid[1][set_idx] && (m_tag[1][set_idx] == tag);
            victim   = m_lru[set_idx];
            exp_hit     = hit0 || hit1;
            exp_wb      = !exp_hit && m_dirty[victim][set_idx];
            exp_wb_addr = {m_tag[victim][set_idx], set_idx, 5'b0};
            exp_rd_addr = {tag, set_idx, 5'b0};
            exp_rdata   = model_word(addr);
            rd_seen = 0;
            wb_seen = 0;

            cpu_req.read  = !is_write;
            cpu_req.write = is_write;
            cpu_req.addr  = addr;
            cpu_req.wdata = $random(seed);
            cpu_req.wmask = rnd[27:24];

            got_resp    = 1'b0;
            first_cycle = 1'b1;
            while (!got_resp) begin
                @(negedge clk);
                if (first_cycle && (cpu_rsp.resp !== exp_hit)) begin
                    mismatch("cpu_rsp.resp (hit timing)", cpu_rsp.resp, exp_hit);
                end
                if (cpu_rsp.resp === 1'b1) begin
                    got_resp = 1'b1;
                    if (!is_write && (cpu_rsp.rdata !== exp_rdata)) begin
                        mismatch("cpu_rsp.rdata", cpu_rsp.rdata, exp_rdata);
                    end
                    if (mem_req.read || mem_req.write) begin
                        problem("memory request still raised while cpu_resp is high");
                    end
                end
                first_cycle = 1'b0;
                @(posedge clk);
                #10;
            end
            if (wb_seen != int'(exp_wb)) mismatch("write-back count", wb_seen, exp_wb);
            if (rd_seen != int'(!exp_hit)) mismatch("read-in count", rd_seen, !exp_hit);

            // update the mirror the way the cache should have
            if (exp_hit) begin
                way = hit1;
                n_hits++;
            end else begin
                way = victim;
                m_tag[way][set_idx]   = tag;
                m_valid[way][set_idx] = 1'b1;
                m_dirty[way][set_idx] = 1'b0;
                n_misses++;
                if (exp_wb) n_wb++;
            end
            m_lru[set_idx] = !way;
            if (is_write) begin
                m_dirty[way][set_idx] = 1'b1;
                ref_mem[addr] = merge_bytes(exp_rdata, cpu_req.wdata, cpu_req.wmask);
                n_writes++;
            end else begin
                n_reads++;
            end
        end
        cpu_req = '0;
        $display("test random_traffic: %0d reads, %0d writes, %0d errors", n_reads, n_writes,
                 n_errors - err_before);

        if (n_misses == 0 || n_wb == 0) problem("traffic never caused a miss or a write-back");
        $display("test eviction_coverage: %0d misses, %0d write-backs", n_misses, n_wb);

        $display("summary: %0d ops, %0d hits, %0d misses, %0d write-backs, %0d errors",
                 n_ops, n_hits, n_misses, n_wb, n_errors);
        if (n_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // worst miss is well under 20 cycles
    initial begin
        #(longint'(n_ops) * 20 * period);
        $display("watchdog: the run did not finish in time, the cache or memory hung");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- cache.f
cache_bus_pkg.sv
cache_core_pkg.sv
cache_control.sv
cache_datapath.sv
cache_top.sv
tb_clock_gen.sv
tb_cache_top.sv

//--- Bender.yml
package:
  name: cache

sources:
  - cache_bus_pkg.sv
  - cache_core_pkg.sv
  - cache_control.sv
  - cache_datapath.sv
  - cache_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_cache_top.sv
